// ==== run.sh ====
#!/bin/sh
# Builds the core slice testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tbCoreSlice \
    -f verilog.f -o simCoreSlice
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simCoreSlice > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Result: PASSED$" sim.log; then
    exit 0
else
    echo "Pass message not found in sim.log"
    exit 1
fi

// ==== src/executeStage.sv ====
`timescale 1ns/1ps

module executeStage (
    input  pipeCtrlPkg::decodeExT        ex,
    input  pipeCtrlPkg::execWbT          wbFwd,
    output logic                         redirectValid,
    output logic [pipeCtrlPkg::XLEN-1:0] redirectPc,
    output logic                         flush,
    output pipeCtrlPkg::execWbT          toWb
);
    import rvIsaPkg::*;
    import pipeCtrlPkg::*;

    logic            fwdA;
    logic            fwdB;
    logic [XLEN-1:0] srcA;
    logic [XLEN-1:0] rd2Fwd;
    logic [XLEN-1:0] srcB;
    logic [XLEN-1:0] aluOut;
    logic            operandsEqual;

    // The instruction one ahead sits in the writeback register and has not
    // reached the register file yet, so its result is taken from there.
    // Decode already dropped regWrite for x0.
    assign fwdA = wbFwd.valid && wbFwd.regWrite && (wbFwd.rd == ex.rs1);
    assign fwdB = wbFwd.valid && wbFwd.regWrite && (wbFwd.rd == ex.rs2);

    assign srcA   = fwdA ? wbFwd.result : ex.rd1;
    assign rd2Fwd = fwdB ? wbFwd.result : ex.rd2;
    assign srcB   = ex.aluSrc ? ex.immExt : rd2Fwd;

    always_comb begin : alu
        case (ex.aluControl)
            aluAdd:  aluOut = srcA + srcB;
            aluSub:  aluOut = srcA - srcB;
            aluAnd:  aluOut = srcA & srcB;
            aluOr:   aluOut = srcA | srcB;
            aluSlt:  aluOut = {{(XLEN-1){1'b0}}, $signed(srcA) < $signed(srcB)};
            default: aluOut = '0;
        endcase
    end

    // beq compares the forwarded register values directly.
    assign operandsEqual = (srcA == rd2Fwd);

    // Both taken beq and jal go to pc plus the immediate.
    // A bubble has jump and branch low, so it never redirects.
    assign redirectValid = ex.jump || (ex.branch && operandsEqual);
    assign redirectPc    = ex.pc + ex.immExt;

    // The word now in decode is on the wrong path whenever execute redirects.
    assign flush = redirectValid;

    always_comb begin : buildPayload
        toWb          = '0;
        toWb.valid    = ex.valid;
        toWb.regWrite = ex.regWrite;
        toWb.rd       = ex.rd;
        // jal links pc plus 4, everything else retires the ALU output.
        toWb.result   = (ex.resultSrc == resPcPlus4) ? ex.pcPlus4 : aluOut;
        // For sw the ALU has formed rs1 plus the S immediate.
        toWb.memWrite  = ex.memWrite;
        toWb.storeAddr = aluOut;
        toWb.storeData = rd2Fwd;
    end

    // A redirect out of a bubble would mean a control bit leaked through
    // decode or the stage register.
    always_comb begin
        assert final (!redirectValid || ex.valid)
            else $error("executeStage: redirect raised without a valid instruction");
    end

endmodule

// ==== src/instrDecoder.sv ====
`timescale 1ns/1ps

module instrDecoder (
    input  logic                         instrValid,
    input  logic [pipeCtrlPkg::XLEN-1:0] instr,
    input  logic [pipeCtrlPkg::XLEN-1:0] pc,
    regPortIf.reader                     regs,
    output pipeCtrlPkg::decodeExT        decoded
);
    import rvIsaPkg::*;
    import pipeCtrlPkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [4:0]      rs1Field;
    logic [4:0]      rs2Field;
    logic [4:0]      rdField;

    // Main control outputs.
    logic            supported;
    logic            usesRs1;
    logic            usesRs2;
    logic            regWrite;
    logic            memWrite;
    logic            jump;
    logic            branch;
    logic            aluSrc;
    resultSrcT       resultSrc;
    aluOpT           aluControl;
    immKindT         immSrc;
    logic [XLEN-1:0] immExt;

    // Fixed RV32I field positions.
    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7   = instr[31:25];
    assign rs1Field = instr[19:15];
    assign rs2Field = instr[24:20];
    assign rdField  = instr[11:7];

    always_comb begin : mainDecode
        supported  = 1'b0;
        usesRs1    = 1'b0;
        usesRs2    = 1'b0;
        regWrite   = 1'b0;
        memWrite   = 1'b0;
        jump       = 1'b0;
        branch     = 1'b0;
        aluSrc     = 1'b0;
        resultSrc  = resAlu;
        aluControl = aluAdd;
        immSrc     = immI;
        case (opcode)
            opRegReg: begin
                supported = 1'b1;
                usesRs1   = 1'b1;
                usesRs2   = 1'b1;
                regWrite  = 1'b1;
                case (funct3)
                    f3AddSub: aluControl = (funct7 == funct7Alt) ? aluSub : aluAdd;
                    f3Slt:    aluControl = aluSlt;
                    f3Or:     aluControl = aluOr;
                    f3And:    aluControl = aluAnd;
                    default:  supported = 1'b0;
                endcase
                // Only sub may carry the alternate funct7.
                if ((funct7 != funct7Base) && !((funct3 == f3AddSub) && (funct7 == funct7Alt))) begin
                    supported = 1'b0;
                end
            end
            opRegImm: begin
                supported = 1'b1;
                usesRs1   = 1'b1;
                regWrite  = 1'b1;
                aluSrc    = 1'b1;
                case (funct3)
                    f3AddSub: aluControl = aluAdd;
                    f3Slt:    aluControl = aluSlt;
                    f3Or:     aluControl = aluOr;
                    f3And:    aluControl = aluAnd;
                    default:  supported = 1'b0;
                endcase
            end
            opStore: begin
                // The address is formed by the ALU adder.
                supported = (funct3 == f3Sw);
                usesRs1   = 1'b1;
                usesRs2   = 1'b1;
                memWrite  = 1'b1;
                aluSrc    = 1'b1;
                immSrc    = immS;
            end
            opBranch: begin
                supported  = (funct3 == f3Beq);
                usesRs1    = 1'b1;
                usesRs2    = 1'b1;
                branch     = 1'b1;
                aluControl = aluSub;
                immSrc     = immB;
            end
            opJal: begin
                supported = 1'b1;
                regWrite  = 1'b1;
                jump      = 1'b1;
                resultSrc = resPcPlus4;
                immSrc    = immJ;
            end
            default: supported = 1'b0;
        endcase
    end

    // Sign extension, with the scattered bits of S, B and J put back in order.
    always_comb begin : immExtend
        case (immSrc)
            immI:    immExt = {{20{instr[31]}}, instr[31:20]};
            immS:    immExt = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            immB:    immExt = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            default: immExt = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        endcase
    end

    // Unused source fields address x0, which never matches a forwarding source.
    assign regs.rs1 = usesRs1 ? rs1Field : 5'd0;
    assign regs.rs2 = usesRs2 ? rs2Field : 5'd0;

    always_comb begin : buildPayload
        decoded = '0;
        if (instrValid && supported) begin
            decoded.valid      = 1'b1;
            decoded.rd1        = regs.rd1;
            decoded.rd2        = regs.rd2;
            decoded.pc         = pc;
            decoded.pcPlus4    = pc + XLEN'(4);
            decoded.immExt     = immExt;
            decoded.rs1        = regs.rs1;
            decoded.rs2        = regs.rs2;
            decoded.rd         = rdField;
            // A write to x0 is dropped here once for the whole pipeline.
            decoded.regWrite   = regWrite && (rdField != 5'd0);
            decoded.resultSrc  = resultSrc;
            decoded.memWrite   = memWrite;
            decoded.jump       = jump;
            decoded.branch     = branch;
            decoded.aluControl = aluControl;
            decoded.aluSrc     = aluSrc;
        end
    end

    // No loads exist, so the memory result code must never leave decode.
    always_comb begin
        assert final (decoded.resultSrc != resMem)
            else $error("instrDecoder: memory result source decoded");
    end

endmodule

// ==== src/pipeCtrlPkg.sv ====
package pipeCtrlPkg;

    // Width of every data word, address and register in the slice.
    localparam int XLEN = 32;

    // Payload handed from decode to execute.
    // An all-zero value is a bubble, since valid is then low and every
    // control bit is inactive.
    typedef struct packed {
        logic                valid;
        // Source operands as read in decode, before any forwarding.
        logic [XLEN-1:0]     rd1;
        logic [XLEN-1:0]     rd2;
        // Instruction address and its fall-through successor.
        logic [XLEN-1:0]     pc;
        logic [XLEN-1:0]     pcPlus4;
        logic [XLEN-1:0]     immExt;
        // Register numbers, used by execute to match forwarding sources.
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        logic [4:0]          rd;
        // Control word, field for field as in the classic pipeline.
        logic                regWrite;
        rvIsaPkg::resultSrcT resultSrc;
        logic                memWrite;
        logic                jump;
        logic                branch;
        rvIsaPkg::aluOpT     aluControl;
        logic                aluSrc;
    } decodeExT;

    // Payload handed from execute to the writeback register.
    // Its output both retires the instruction and feeds forwarding.
    typedef struct packed {
        logic            valid;
        logic            regWrite;
        logic [4:0]      rd;
        logic [XLEN-1:0] result;
        // Store request, taken as-is to the top level ports.
        logic            memWrite;
        logic [XLEN-1:0] storeAddr;
        logic [XLEN-1:0] storeData;
    } execWbT;

endpackage

// ==== src/pipeReg.sv ====
`timescale 1ns/1ps

module pipeReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    flush,
    input  payloadT d,
    output payloadT q
);

    // Both reset and flush load the all-zero payload.
    // With valid low and every control bit inactive, that is a bubble.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            q <= '0;
        end else if (flush) begin
            // The instruction in decode was fetched down the wrong path.
            q <= '0;
        end else begin
            q <= d;
        end
    end

    // A flush must leave a bubble in the stage for the following cycle,
    // so nothing from the squashed path reaches execute.
    assert property (@(posedge clk) disable iff (rst) flush |=> (q == payloadT'('0)))
        else $error("pipeReg: stage not empty after flush");

endmodule

// ==== src/regFile.sv ====
`timescale 1ns/1ps

module regFile (
    input  logic      clk,
    input  logic      rst,
    regPortIf.storage regs
);
    import pipeCtrlPkg::*;

    // Only x1 to x31 have storage. x0 reads as zero by construction.
    logic [XLEN-1:0] mem [1:31];

    // A read of the register being written this cycle sees the new value.
    // This lets decode pick up a result two instructions back without
    // a separate forwarding path.
    function automatic logic [XLEN-1:0] readReg(input logic [4:0] addr);
        logic [XLEN-1:0] value;
        if (addr == 5'd0) begin
            value = '0;
        end else if (regs.we && (regs.wAddr == addr)) begin
            value = regs.wData;
        end else begin
            value = mem[addr];
        end
        return value;
    endfunction

    always_comb begin : readPorts
        regs.rd1 = readReg(regs.rs1);
        regs.rd2 = readReg(regs.rs2);
    end

    // The architectural state starts cleared.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                mem[i] <= '0;
            end
        end else if (regs.we && (regs.wAddr != 5'd0)) begin
            mem[regs.wAddr] <= regs.wData;
        end
    end

    // Decode drops regWrite for rd x0, so no write to x0 may ever
    // reach this port from the writeback register.
    assert property (@(posedge clk) disable iff (rst) regs.we |-> (regs.wAddr != 5'd0))
        else $error("regFile: write to x0 reached the register file");

endmodule

// ==== src/regPortIf.sv ====
`timescale 1ns/1ps

interface regPortIf;
    import pipeCtrlPkg::*;

    // Two asynchronous read ports.
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [XLEN-1:0] rd1;
    logic [XLEN-1:0] rd2;

    // One write port, committed at the clock edge.
    logic            we;
    logic [4:0]      wAddr;
    logic [XLEN-1:0] wData;

    // Decode side picks the addresses and gets the operands back.
    modport reader (output rs1, rs2, input rd1, rd2);

    // Writeback side commits one result per cycle.
    modport writer (output we, wAddr, wData);

    // The register array itself.
    modport storage (input rs1, rs2, we, wAddr, wData, output rd1, rd2);

endinterface

// ==== src/rvCoreSlice.sv ====
`timescale 1ns/1ps

module rvCoreSlice (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         instrValid,
    input  logic [pipeCtrlPkg::XLEN-1:0] instr,
    input  logic [pipeCtrlPkg::XLEN-1:0] pc,
    output logic                         redirectValid,
    output logic [pipeCtrlPkg::XLEN-1:0] redirectPc,
    output logic                         wbValid,
    output logic [4:0]                   wbRd,
    output logic [pipeCtrlPkg::XLEN-1:0] wbData,
    output logic                         storeValid,
    output logic [pipeCtrlPkg::XLEN-1:0] storeAddr,
    output logic [pipeCtrlPkg::XLEN-1:0] storeData
);
    import pipeCtrlPkg::*;

    decodeExT idExD;
    decodeExT idExQ;
    execWbT   exWbD;
    execWbT   exWbQ;
    logic     idExFlush;

    regPortIf regBus ();

    regFile u_regFile (
        .clk  (clk),
        .rst  (rst),
        .regs (regBus.storage)
    );

    instrDecoder u_instrDecoder (
        .instrValid (instrValid),
        .instr      (instr),
        .pc         (pc),
        .regs       (regBus.reader),
        .decoded    (idExD)
    );

    pipeReg #(.payloadT(decodeExT)) idExReg (
        .clk   (clk),
        .rst   (rst),
        .flush (idExFlush),
        .d     (idExD),
        .q     (idExQ)
    );

    executeStage u_executeStage (
        .ex            (idExQ),
        .wbFwd         (exWbQ),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc),
        .flush         (idExFlush),
        .toWb          (exWbD)
    );

    // Nothing behind writeback can be on a wrong path, so this stage never flushes.
    pipeReg #(.payloadT(execWbT)) exWbReg (
        .clk   (clk),
        .rst   (rst),
        .flush (1'b0),
        .d     (exWbD),
        .q     (exWbQ)
    );

    // Writeback drives the register file write port from the stage output.
    assign regBus.we    = wbValid;
    assign regBus.wAddr = exWbQ.rd;
    assign regBus.wData = exWbQ.result;

    // Retirement events, all taken from the writeback register output.
    assign wbValid    = exWbQ.valid && exWbQ.regWrite;
    assign wbRd       = exWbQ.rd;
    assign wbData     = exWbQ.result;
    assign storeValid = exWbQ.valid && exWbQ.memWrite;
    assign storeAddr  = exWbQ.storeAddr;
    assign storeData  = exWbQ.storeData;

endmodule

// ==== src/rvIsaPkg.sv ====
package rvIsaPkg;

    // Major opcodes of the supported RV32I subset.
    localparam logic [6:0] opRegReg = 7'b0110011;
    localparam logic [6:0] opRegImm = 7'b0010011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;

    // Funct3 codes for the ALU group, shared by register and immediate forms.
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    // Funct3 codes that pick sw among the stores and beq among the branches.
    localparam logic [2:0] f3Sw     = 3'b010;
    localparam logic [2:0] f3Beq    = 3'b000;

    // Funct7 of the plain register operations, and the alternate form that turns add into sub.
    localparam logic [6:0] funct7Base = 7'b0000000;
    localparam logic [6:0] funct7Alt  = 7'b0100000;

    // ALU operation codes. The encoding follows the classic single-cycle
    // ALUControl table, so a zero code is an add.
    typedef enum logic [2:0] {
        aluAdd = 3'b000,
        aluSub = 3'b001,
        aluAnd = 3'b010,
        aluOr  = 3'b011,
        aluSlt = 3'b101
    } aluOpT;

    // Immediate formats that the extender knows how to assemble.
    typedef enum logic [1:0] {
        immI = 2'b00,
        immS = 2'b01,
        immB = 2'b10,
        immJ = 2'b11
    } immKindT;

    // Writeback source select. The memory code is kept for width only.
    typedef enum logic [1:0] {
        resAlu     = 2'b00,
        resMem     = 2'b01,
        resPcPlus4 = 2'b10
    } resultSrcT;

endpackage

// ==== test/sliceVectors.txt ====
# Program: P <hex instruction word>, placed from address 0 in steps of 4.
# Events: W <rd decimal> <hex data> or S <hex address> <hex data>, in retirement order.
P 00500093  # 00 addi x1, x0, 5
P FFD00113  # 04 addi x2, x0, -3
P 002081B3  # 08 add  x3, x1, x2
P 40118233  # 0C sub  x4, x3, x1
P 001222B3  # 10 slt  x5, x4, x1
P FFF0A313  # 14 slti x6, x1, -1
P 0F017393  # 18 andi x7, x2, 0x0F0
P F003E413  # 1C ori  x8, x7, -256
P 002474B3  # 20 and  x9, x8, x2
P 0070E533  # 24 or   x10, x1, x7
P 00708013  # 28 addi x0, x1, 7
P 001005B3  # 2C add  x11, x0, x1
P 00150613  # 30 addi x12, x10, 1
P 00C0A5A3  # 34 sw   x12, 11(x1)
P FE452C23  # 38 sw   x4, -8(x10)
P 00B08663  # 3C beq  x1, x11, +12 (taken)
P 06300693  # 40 addi x13, x0, 99 (wrong path)
P 06200713  # 44 addi x14, x0, 98 (skipped)
P 00208463  # 48 beq  x1, x2, +8 (not taken)
P 008007EF  # 4C jal  x15, +8
P 04D00813  # 50 addi x16, x0, 77 (wrong path)
P 00178893  # 54 addi x17, x15, 1
P 01102023  # 58 sw   x17, 0(x0)
P 0000006F  # 5C jal  x0, 0 (end)
W 1 00000005   # 5
W 2 FFFFFFFD   # -3
W 3 00000002   # 5 + -3
W 4 FFFFFFFD   # 2 - 5
W 5 00000001   # -3 < 5 signed
W 6 00000000   # 5 < -1 is false
W 7 000000F0   # 0xFFFFFFFD and 0xF0
W 8 FFFFFFF0   # 0xF0 or 0xFFFFFF00
W 9 FFFFFFF0   # 0xFFFFFFF0 and 0xFFFFFFFD
W 10 000000F5  # 5 or 0xF0
W 11 00000005  # x0 reads zero
W 12 000000F6  # 0xF5 + 1
S 00000010 000000F6  # 5 + 11
S 000000ED FFFFFFFD  # 0xF5 - 8
W 15 00000050  # jal links 0x4C + 4
W 17 00000051  # 0x50 + 1
S 00000000 00000051  # 0 + 0

// ==== test/tbCoreSlice.sv ====
`timescale 1ns/1ps

module tbCoreSlice;

    localparam int maxWords  = 64;
    localparam int maxEvents = 64;
    // A jal x0 to its own address ends the program.
    localparam logic [31:0] selfJal = 32'h0000006f;

    logic        clk        = 1'b0;
    logic        rst        = 1'b1;
    logic        instrValid = 1'b0;
    logic [31:0] instr      = 32'd0;
    logic [31:0] pc         = 32'd0;
    logic        redirectValid;
    logic [31:0] redirectPc;
    logic        wbValid;
    logic [4:0]  wbRd;
    logic [31:0] wbData;
    logic        storeValid;
    logic [31:0] storeAddr;
    logic [31:0] storeData;

    // Program image and expected retirement trace, both from the vectors file.
    logic [31:0] prog [0:maxWords-1];
    logic [7:0]  evKind [0:maxEvents-1];
    logic [31:0] evA [0:maxEvents-1];
    logic [31:0] evB [0:maxEvents-1];
    int          progLen = 0;
    int          evCount = 0;
    int          evIdx   = 0;

    int valueErrors   = 0;
    int extraEvents   = 0;
    int missingEvents = 0;
    int resetErrors   = 0;
    int timeoutErrors = 0;
    int fileErrors    = 0;

    int          cycle       = 0;
    int          sinceReset  = 0;
    int          drainCycles = 0;
    int          limit       = 0;
    logic [31:0] fetchPc     = 32'd0;
    logic        fetchDone   = 1'b0;

    rvCoreSlice DUT (
        .clk           (clk),
        .rst           (rst),
        .instrValid    (instrValid),
        .instr         (instr),
        .pc            (pc),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc),
        .wbValid       (wbValid),
        .wbRd          (wbRd),
        .wbData        (wbData),
        .storeValid    (storeValid),
        .storeAddr     (storeAddr),
        .storeData     (storeData)
    );

    // 40 ns clock period.
    always #20 clk = ~clk;

    // Reads program words (P) and expected events (W, S). A # starts a comment
    // that runs to the end of the line.
    task automatic loadVectors();
        int              fd;
        int              code;
        logic [7:0]      tag;
        logic [31:0]     a;
        logic [31:0]     b;
        logic [8*128-1:0] rest;
        for (int i = 0; i < maxWords; i++) begin
            prog[i] = 32'd0;
        end
        fd = $fopen("test/sliceVectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vectors file test/sliceVectors.txt");
            fileErrors++;
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", tag);
            if (code != 1) begin
                break;
            end
            case (tag)
                "#": code = $fgets(rest, fd);
                "P": begin
                    code = $fscanf(fd, "%h", a);
                    if (progLen < maxWords) begin
                        prog[progLen] = a;
                        progLen++;
                    end else begin
                        $display("The vectors file holds more program words than fit");
                        fileErrors++;
                    end
                end
                "W", "S": begin
                    if (tag == "W") begin
                        code = $fscanf(fd, "%d %h", a, b);
                    end else begin
                        code = $fscanf(fd, "%h %h", a, b);
                    end
                    if (evCount < maxEvents) begin
                        evKind[evCount] = tag;
                        evA[evCount]    = a;
                        evB[evCount]    = b;
                        evCount++;
                    end else begin
                        $display("The vectors file holds more events than fit");
                        fileErrors++;
                    end
                end
                default: begin
                    $display("Unknown line tag %s in the vectors file", tag);
                    fileErrors++;
                    code = $fgets(rest, fd);
                end
            endcase
        end
        $fclose(fd);
    endtask

    // Compares one retired event with the next entry of the expected trace.
    task automatic checkEvent(input logic [7:0] kind, input logic [31:0] a,
                              input logic [31:0] b);
        if (evIdx >= evCount) begin
            $display("Unexpected %s event %h %h after the last expected event", kind, a, b);
            extraEvents++;
        end else begin
            if (evKind[evIdx] != kind) begin
                $display("[FAIL] %0t: event %0d is %s %h %h, expected a %s event",
                         $time, evIdx, kind, a, b, evKind[evIdx]);
                valueErrors++;
            end else if ((evA[evIdx] != a) || (evB[evIdx] != b)) begin
                $display("[FAIL] %0t: event %0d %s got %h %h, expected %h %h",
                         $time, evIdx, kind, a, b, evA[evIdx], evB[evIdx]);
                valueErrors++;
            end
            evIdx++;
        end
    endtask

    // Fetch model. It follows a redirect in the cycle after redirectValid,
    // otherwise it steps by 4 after each word it presents.
    always @(posedge clk) begin : fetchModel
        logic [31:0] nextPc;
        if (rst) begin
            instrValid <= 1'b0;
            fetchPc    <= 32'd0;
            fetchDone  <= 1'b0;
        end else begin
            nextPc = redirectValid ? redirectPc : fetchPc;
            if (fetchDone || (($urandom % 4) == 0)) begin
                // A bubble keeps the fetch address where it is.
                instrValid <= 1'b0;
                fetchPc    <= nextPc;
            end else begin
                instrValid <= 1'b1;
                instr      <= prog[nextPc[7:2]];
                pc         <= nextPc;
                fetchPc    <= nextPc + 32'd4;
                if (prog[nextPc[7:2]] == selfJal) begin
                    fetchDone <= 1'b1;
                end
            end
        end
    end

    // Watches the retirement ports and counts cycles.
    always @(posedge clk) begin : monitor
        cycle <= cycle + 1;
        if (fetchDone) begin
            drainCycles <= drainCycles + 1;
        end
        if (rst || (sinceReset < 2)) begin
            // The pipeline is empty here, so nothing may retire or redirect.
            if (wbValid || storeValid || redirectValid) begin
                $display("Outputs active during or right after reset at %0t", $time);
                resetErrors++;
            end
        end
        if (!rst) begin
            sinceReset <= sinceReset + 1;
            if (wbValid) begin
                checkEvent("W", {27'd0, wbRd}, wbData);
            end
            if (storeValid) begin
                checkEvent("S", storeAddr, storeData);
            end
        end
    end

    initial begin : mainFlow
        int total;
        void'($urandom(46));
        loadVectors();
        limit = 6 * progLen + 50;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        // Run until the terminal jal has been fetched and the pipeline drained.
        while (!(fetchDone && (drainCycles >= 6)) && (cycle < limit)) begin
            @(posedge clk);
        end
        @(negedge clk);
        if (!(fetchDone && (drainCycles >= 6))) begin
            $display("Timeout after %0d cycles before the program finished", cycle);
            timeoutErrors++;
        end
        if (evIdx < evCount) begin
            $display("Missing events at end of run: %0d of %0d expected events never retired",
                     evCount - evIdx, evCount);
            missingEvents = evCount - evIdx;
        end
        total = valueErrors + extraEvents + missingEvents + resetErrors + timeoutErrors
              + fileErrors;
        $display("Errors: value=%0d extra=%0d missing=%0d reset=%0d timeout=%0d file=%0d",
                 valueErrors, extraEvents, missingEvents, resetErrors, timeoutErrors,
                 fileErrors);
        if (total == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
src/rvIsaPkg.sv
src/pipeCtrlPkg.sv
src/regPortIf.sv
src/regFile.sv
src/instrDecoder.sv
src/pipeReg.sv
src/executeStage.sv
src/rvCoreSlice.sv
test/tbCoreSlice.sv
